//--- logic/ising_pkg.sv
/*
 * Shared widths and types of the digital Ising annealing core.
 * FIELD_BIT and ENERGY_BIT are sized for NUM_SPIN = 8 with 4-bit J and h.
 * Raise them together with NUM_SPIN, BIT_J or BIT_H.
 */
package ising_pkg;

    localparam int NUM_SPIN     = 8;
    localparam int BIT_J        = 4;
    localparam int BIT_H        = 4;
    localparam int ADDR_BIT     = 3;
    localparam int FIELD_BIT    = 8;
    localparam int ENERGY_BIT   = 12;
    localparam int FIFO_DEPTH   = 2;
    localparam int FIFO_PTR_BIT = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_BIT = $clog2(FIFO_DEPTH + 1);
    localparam int J_ROW_BIT    = NUM_SPIN * BIT_J;

    typedef logic [NUM_SPIN-1:0]           spin_vec_t;
    typedef logic signed [BIT_J-1:0]       coup_t;
    typedef logic signed [BIT_H-1:0]       bias_t;
    typedef coup_t [NUM_SPIN-1:0]          j_row_t;
    typedef bias_t [NUM_SPIN-1:0]          h_vec_t;
    typedef logic signed [FIELD_BIT-1:0]   field_t;
    typedef logic signed [ENERGY_BIT-1:0]  energy_t;

    typedef enum logic [2:0] {
        OP_NOP,
        OP_WRITE_J,
        OP_WRITE_H,
        OP_LOAD_SPIN,
        OP_WRITE_MASK
    } host_op_e;

    // Data holds a J row, a whole h vector, or a spin vector in the low bits
    typedef struct packed {
        host_op_e               op;
        logic [ADDR_BIT-1:0]    addr;
        logic [J_ROW_BIT-1:0]   data;
    } host_wr_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SWEEP,
        ST_DRAIN
    } sweep_state_e;

    typedef struct packed {
        logic                   valid;
        logic [ADDR_BIT-1:0]    addr;
    } row_req_t;

    typedef struct packed {
        logic                   valid;
        logic [ADDR_BIT-1:0]    idx;
        j_row_t                 row;
        bias_t                  h;
    } row_data_t;

    typedef struct packed {
        spin_vec_t              spins;
        energy_t                energy;
    } sweep_result_t;

    // h_i plus sum of J_ij * s_j
    function automatic field_t row_field(input j_row_t row, input bias_t bias,
                                         input spin_vec_t spins);
        field_t acc;
        acc = field_t'(bias);
        for (int j = 0; j < NUM_SPIN; j++) begin
            if (spins[j]) begin
                acc = acc + field_t'(row[j]);
            end else begin
                acc = acc - field_t'(row[j]);
            end
        end
        return acc;
    endfunction

endpackage

//--- logic/coupling_mem.sv
/*
 * J rows, h bias, flip mask and host opcode decode.
 * A row read returns its data and bias one cycle after the request.
 * OP_LOAD_SPIN is not stored here, it is passed on as a one-cycle pulse.
 */
`timescale 1ns/1ps

module coupling_mem (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  ising_pkg::host_wr_t   host_wr_i,
    input  ising_pkg::row_req_t   row_req_i,
    output ising_pkg::row_data_t  row_data_o,
    output ising_pkg::spin_vec_t  mask_o,
    output logic                  load_spin_o,
    output ising_pkg::spin_vec_t  init_spin_o
);
    import ising_pkg::*;

    j_row_t                 j_mem [NUM_SPIN];
    h_vec_t                 h_q;
    spin_vec_t              mask_q;
    logic                   rd_valid_q;
    logic [ADDR_BIT-1:0]    rd_idx_q;
    j_row_t                 rd_row_q;
    bias_t                  rd_h_q;

    //////////////////////////////////////////////////////////////////////
    // Host writes
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_SPIN; i++) begin
                j_mem[i] <= '0;
            end
            h_q    <= '0;
            mask_q <= '0;
        end else begin
            case (host_wr_i.op)
                OP_WRITE_J:    j_mem[host_wr_i.addr] <= j_row_t'(host_wr_i.data);
                OP_WRITE_H:    h_q <= h_vec_t'(host_wr_i.data);
                OP_WRITE_MASK: mask_q <= host_wr_i.data[NUM_SPIN-1:0];
                default: ;
            endcase
        end
    end

    // Spin load goes straight to the spin register in sweep_ctrl
    assign load_spin_o = (host_wr_i.op == OP_LOAD_SPIN);
    assign init_spin_o = host_wr_i.data[NUM_SPIN-1:0];
    assign mask_o      = mask_q;

    //////////////////////////////////////////////////////////////////////
    // Row read port
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= row_req_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (row_req_i.valid) begin
            rd_idx_q <= row_req_i.addr;
            rd_row_q <= j_mem[row_req_i.addr];
            rd_h_q   <= h_q[row_req_i.addr];
        end
    end

    assign row_data_o = '{
        valid: rd_valid_q,
        idx:   rd_idx_q,
        row:   rd_row_q,
        h:     rd_h_q
    };

endmodule

//--- logic/field_unit.sv
/*
 * Local field of one spin per cycle, from the snapshot spins.
 * Output is registered, one cycle after the row data.
 */
`timescale 1ns/1ps

module field_unit (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  ising_pkg::row_data_t                row_data_i,
    input  ising_pkg::spin_vec_t                spins_i,
    output logic                                upd_valid_o,
    output logic [ising_pkg::ADDR_BIT-1:0]      upd_idx_o,
    output logic                                upd_spin_o,
    output logic                                upd_zero_o
);
    import ising_pkg::*;

    field_t                 field;
    logic                   valid_q;
    logic [ADDR_BIT-1:0]    idx_q;
    logic                   spin_q;
    logic                   zero_q;

    assign field = row_field(row_data_i.row, row_data_i.h, spins_i);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= row_data_i.valid;
        end
    end

    // Positive field proposes +1, zero field is flagged for keep
    always_ff @(posedge clk_i) begin
        if (row_data_i.valid) begin
            idx_q  <= row_data_i.idx;
            spin_q <= (field > 0);
            zero_q <= (field == '0);
        end
    end

    assign upd_valid_o = valid_q;
    assign upd_idx_o   = idx_q;
    assign upd_spin_o  = spin_q;
    assign upd_zero_o  = zero_q;

endmodule

//--- logic/energy_unit.sv
/*
 * Energy of the snapshot spins, accumulated one row per cycle.
 * Rows must arrive in order, starting at index 0 and ending at NUM_SPIN-1.
 * The done pulse comes with the registered total.
 */
`timescale 1ns/1ps

module energy_unit (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  ising_pkg::row_data_t  row_data_i,
    input  ising_pkg::spin_vec_t  spins_i,
    output ising_pkg::energy_t    energy_o,
    output logic                  done_o
);
    import ising_pkg::*;

    field_t     row_sum;
    energy_t    term;
    energy_t    acc_q;
    logic       done_q;

    // Row term is -s_i * (sum_j J_ij * s_j + h_i)
    always_comb begin
        row_sum = row_field(row_data_i.row, row_data_i.h, spins_i);
        if (spins_i[row_data_i.idx]) begin
            term = -energy_t'(row_sum);
        end else begin
            term = energy_t'(row_sum);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            acc_q  <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= row_data_i.valid
                   && (row_data_i.idx == ADDR_BIT'(NUM_SPIN - 1));
            if (row_data_i.valid) begin
                // First row restarts the sum
                if (row_data_i.idx == '0) begin
                    acc_q <= term;
                end else begin
                    acc_q <= acc_q + term;
                end
            end
        end
    end

    assign energy_o = acc_q;
    assign done_o   = done_q;

endmodule

//--- logic/sweep_ctrl.sv
/*
 * Sweep FSM, row addressing and the spin register.
 * Spins seen by the datapath stay fixed for the whole sweep.
 * A start is dropped while busy or while the result FIFO is full.
 */
`timescale 1ns/1ps

module sweep_ctrl (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                start_i,
    input  logic                                fifo_full_i,
    input  logic                                load_spin_i,
    input  ising_pkg::spin_vec_t                init_spin_i,
    input  ising_pkg::spin_vec_t                mask_i,
    input  logic                                upd_valid_i,
    input  logic [ising_pkg::ADDR_BIT-1:0]      upd_idx_i,
    input  logic                                upd_spin_i,
    input  logic                                upd_zero_i,
    input  ising_pkg::energy_t                  energy_i,
    input  logic                                energy_done_i,
    output ising_pkg::row_req_t                 row_req_o,
    output ising_pkg::spin_vec_t                spins_o,
    output logic                                push_o,
    output ising_pkg::sweep_result_t            result_o,
    output logic                                busy_o
);
    import ising_pkg::*;

    sweep_state_e           state_q;
    logic [ADDR_BIT-1:0]    row_cnt_q;
    spin_vec_t              spin_q;
    spin_vec_t              new_q;
    spin_vec_t              new_d;
    logic                   push_q;
    sweep_result_t          result_q;
    logic                   start_ok;

    assign busy_o   = (state_q != ST_IDLE) || push_q;
    assign start_ok = start_i && !busy_o && !fifo_full_i;

    // Masked spins and zero fields keep the snapshot value
    always_comb begin
        new_d = new_q;
        if (upd_valid_i && !mask_i[upd_idx_i] && !upd_zero_i) begin
            new_d[upd_idx_i] = upd_spin_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q   <= ST_IDLE;
            row_cnt_q <= '0;
            spin_q    <= '0;
            new_q     <= '0;
            push_q    <= 1'b0;
        end else begin
            push_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (load_spin_i) begin
                        spin_q <= init_spin_i;
                    end
                    if (start_ok) begin
                        state_q   <= ST_SWEEP;
                        row_cnt_q <= '0;
                        new_q     <= spin_q;
                    end
                end
                ST_SWEEP: begin
                    new_q     <= new_d;
                    row_cnt_q <= row_cnt_q + 1'b1;
                    if (row_cnt_q == ADDR_BIT'(NUM_SPIN - 1)) begin
                        state_q <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    new_q <= new_d;
                    // Last field update lands together with done
                    if (energy_done_i) begin
                        spin_q  <= new_d;
                        push_q  <= 1'b1;
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_DRAIN && energy_done_i) begin
            result_q <= '{spins: new_d, energy: energy_i};
        end
    end

    assign row_req_o = '{valid: (state_q == ST_SWEEP), addr: row_cnt_q};
    assign spins_o   = spin_q;
    assign push_o    = push_q;
    assign result_o  = result_q;

endmodule

//--- logic/result_fifo.sv
/*
 * Small circular FIFO of sweep results.
 * Pop on empty is dropped; push on full only goes in with a pop.
 */
`timescale 1ns/1ps

module result_fifo (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      push_i,
    input  ising_pkg::sweep_result_t  push_data_i,
    input  logic                      pop_i,
    output logic                      full_o,
    output logic                      valid_o,
    output ising_pkg::sweep_result_t  head_o
);
    import ising_pkg::*;

    sweep_result_t              mem [FIFO_DEPTH];
    logic [FIFO_PTR_BIT-1:0]    wr_ptr_q;
    logic [FIFO_PTR_BIT-1:0]    rd_ptr_q;
    logic [FIFO_CNT_BIT-1:0]    count_q;
    logic                       do_push;
    logic                       do_pop;

    assign full_o  = (count_q == FIFO_CNT_BIT'(FIFO_DEPTH));
    assign valid_o = (count_q != '0);
    assign do_pop  = pop_i && valid_o;
    assign do_push = push_i && (!full_o || do_pop);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == FIFO_PTR_BIT'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == FIFO_PTR_BIT'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    assign head_o = mem[rd_ptr_q];

endmodule

//--- logic/ising_core.sv
/*
 * Digital Ising annealing core, one full sweep per start pulse.
 * Latency from accepted start to result in the FIFO is NUM_SPIN+3 cycles.
 * Host writes are only allowed while busy_o is low.
 */
`timescale 1ns/1ps

module ising_core (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  ising_pkg::host_wr_t       host_wr_i,
    input  logic                      start_i,
    input  logic                      pop_i,
    output logic                      busy_o,
    output logic                      result_valid_o,
    output ising_pkg::sweep_result_t  result_o
);
    import ising_pkg::*;

    row_req_t               row_req;
    row_data_t              row_data;
    spin_vec_t              mask;
    spin_vec_t              init_spin;
    spin_vec_t              snap_spins;
    logic                   load_spin;
    logic                   upd_valid;
    logic [ADDR_BIT-1:0]    upd_idx;
    logic                   upd_spin;
    logic                   upd_zero;
    energy_t                energy;
    logic                   energy_done;
    logic                   fifo_full;
    logic                   push;
    sweep_result_t          push_data;

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////
    coupling_mem u_coupling_mem (
        .clk_i          (clk_i          ),
        .rst_n_i        (rst_n_i        ),
        .host_wr_i      (host_wr_i      ),
        .row_req_i      (row_req        ),
        .row_data_o     (row_data       ),
        .mask_o         (mask           ),
        .load_spin_o    (load_spin      ),
        .init_spin_o    (init_spin      )
    );

    //////////////////////////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////////////////////////
    field_unit u_field_unit (
        .clk_i          (clk_i          ),
        .rst_n_i        (rst_n_i        ),
        .row_data_i     (row_data       ),
        .spins_i        (snap_spins     ),
        .upd_valid_o    (upd_valid      ),
        .upd_idx_o      (upd_idx        ),
        .upd_spin_o     (upd_spin       ),
        .upd_zero_o     (upd_zero       )
    );

    energy_unit u_energy_unit (
        .clk_i          (clk_i          ),
        .rst_n_i        (rst_n_i        ),
        .row_data_i     (row_data       ),
        .spins_i        (snap_spins     ),
        .energy_o       (energy         ),
        .done_o         (energy_done    )
    );

    //////////////////////////////////////////////////////////////////////
    // Control and results
    //////////////////////////////////////////////////////////////////////
    sweep_ctrl u_sweep_ctrl (
        .clk_i          (clk_i          ),
        .rst_n_i        (rst_n_i        ),
        .start_i        (start_i        ),
        .fifo_full_i    (fifo_full      ),
        .load_spin_i    (load_spin      ),
        .init_spin_i    (init_spin      ),
        .mask_i         (mask           ),
        .upd_valid_i    (upd_valid      ),
        .upd_idx_i      (upd_idx        ),
        .upd_spin_i     (upd_spin       ),
        .upd_zero_i     (upd_zero       ),
        .energy_i       (energy         ),
        .energy_done_i  (energy_done    ),
        .row_req_o      (row_req        ),
        .spins_o        (snap_spins     ),
        .push_o         (push           ),
        .result_o       (push_data      ),
        .busy_o         (busy_o         )
    );

    result_fifo u_result_fifo (
        .clk_i          (clk_i          ),
        .rst_n_i        (rst_n_i        ),
        .push_i         (push           ),
        .push_data_i    (push_data      ),
        .pop_i          (pop_i          ),
        .full_o         (fifo_full      ),
        .valid_o        (result_valid_o ),
        .head_o         (result_o       )
    );

endmodule

//--- sim/tb_clock_gen.sv
/*
 * Free-running testbench clock, starts low.
 */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk_o
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

//--- sim/ising_checker.sv
/*
 * Port-level assertions of ising_core, bound into the DUT.
 * Failures are counted in assert_fails for the closing report.
 */
`timescale 1ns/1ps

module ising_checker (
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  logic    start_i,
    input  logic    pop_i,
    input  logic    busy_i,
    input  logic    result_valid_i,
    input  logic    fifo_full_i
);
    import ising_pkg::*;

    localparam int LATENCY = NUM_SPIN + 3;

    int assert_fails = 0;

    busy_after_reset: assert property (@(posedge clk_i) !rst_n_i |=> !busy_i)
        else begin
            $error("busy_o high in the cycle after reset");
            assert_fails++;
        end

    // Head stays until it is popped
    valid_until_pop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        result_valid_i && !pop_i |=> result_valid_i)
        else begin
            $error("result_valid_o dropped without a pop");
            assert_fails++;
        end

    sweep_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        start_i && !busy_i && !fifo_full_i |-> ##LATENCY busy_i ##1 !busy_i)
        else begin
            $error("busy_o did not fall %0d cycles after an accepted start", LATENCY);
            assert_fails++;
        end

endmodule

//--- sim/tb_ising_core.sv
/*
 * Table-driven testbench of the Ising core with its own sweep model.
 * Host writes are only made while the core is idle.
 * The last table case must run FIFO_DEPTH sweeps to fill the result FIFO.
 */
`timescale 1ns/1ps

module tb_ising_core;
    import ising_pkg::*;

    localparam int NUM_CASES  = 4;
    localparam int MAX_SWEEPS = 4;
    localparam int LATENCY    = NUM_SPIN + 3;

    typedef struct {
        spin_vec_t  init;
        spin_vec_t  mask;
        h_vec_t     h;
        bit         rand_j;
        int         sweeps;
        bit         hold;
    } case_t;

    logic           clk;
    logic           rst_n;
    host_wr_t       host_wr;
    logic           start;
    logic           pop;
    logic           busy;
    logic           result_valid;
    sweep_result_t  result;

    case_t          cases [NUM_CASES];
    j_row_t         j_table [NUM_SPIN];
    int             j_model [NUM_SPIN][NUM_SPIN];
    int             h_model [NUM_SPIN];
    spin_vec_t      s_model;
    spin_vec_t      m_model;
    spin_vec_t      exp_spins [$];
    energy_t        exp_energy [$];
    integer         seed = 60516;
    int             value_errs = 0;
    int             other_errs = 0;
    bit             timed_out = 1'b0;

    tb_clock_gen #(.PERIOD_NS(40)) u_clock (.clk_o(clk));

    ising_core dut (
        .clk_i          (clk            ),
        .rst_n_i        (rst_n          ),
        .host_wr_i      (host_wr        ),
        .start_i        (start          ),
        .pop_i          (pop            ),
        .busy_o         (busy           ),
        .result_valid_o (result_valid   ),
        .result_o       (result         )
    );

    bind ising_core ising_checker u_checker (
        .clk_i          (clk_i          ),
        .rst_n_i        (rst_n_i        ),
        .start_i        (start_i        ),
        .pop_i          (pop_i          ),
        .busy_i         (busy_o         ),
        .result_valid_i (result_valid_o ),
        .fifo_full_i    (fifo_full      )
    );

    //////////////////////////////////////////////////////////////////////
    // Stimulus tables
    //////////////////////////////////////////////////////////////////////
    // Row 3 is all zero so its field is just h_3
    function automatic void fill_tables();
        j_table[0] = 32'h1E2F_0D31;
        j_table[1] = 32'hF203_1E02;
        j_table[2] = 32'h2D01_F310;
        j_table[3] = 32'h0000_0000;
        j_table[4] = 32'h31F0_2E1D;
        j_table[5] = 32'hE102_0F23;
        j_table[6] = 32'h0F31_2D01;
        j_table[7] = 32'h12E0_3F1D;
        cases[0] = '{init: 8'hA5, mask: 8'h00, h: 32'h1F20_0E31,
                     rand_j: 1'b0, sweeps: 1, hold: 1'b0};
        cases[1] = '{init: 8'h3C, mask: 8'h81, h: 32'h21F0_0312,
                     rand_j: 1'b0, sweeps: 1, hold: 1'b0};
        cases[2] = '{init: 8'h5A, mask: 8'h00, h: 32'h0102_F1E0,
                     rand_j: 1'b1, sweeps: MAX_SWEEPS, hold: 1'b0};
        cases[3] = '{init: 8'hC3, mask: 8'h10, h: 32'h1010_0F0F,
                     rand_j: 1'b1, sweeps: FIFO_DEPTH, hold: 1'b1};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////
    task automatic model_sweep();
        int         field [NUM_SPIN];
        int         energy;
        spin_vec_t  next;
        energy = 0;
        next   = s_model;
        for (int i = 0; i < NUM_SPIN; i++) begin
            field[i] = h_model[i];
            for (int j = 0; j < NUM_SPIN; j++) begin
                field[i] += s_model[j] ? j_model[i][j] : -j_model[i][j];
            end
            energy -= s_model[i] ? field[i] : -field[i];
            if (!m_model[i] && field[i] != 0) begin
                next[i] = (field[i] > 0);
            end
        end
        s_model = next;
        exp_spins.push_back(next);
        exp_energy.push_back(energy_t'(energy));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic check_spins(input string name, input spin_vec_t got, input spin_vec_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_energy(input string name, input energy_t got, input energy_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
            value_errs++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Bus tasks
    //////////////////////////////////////////////////////////////////////
    task automatic write_host(input host_op_e wr_op, input logic [ADDR_BIT-1:0] wr_addr,
                              input logic [J_ROW_BIT-1:0] wr_data);
        @(posedge clk);
        #2;
        host_wr = '{op: wr_op, addr: wr_addr, data: wr_data};
        @(posedge clk);
        #2;
        host_wr = '{op: OP_NOP, addr: '0, data: '0};
    endtask

    task automatic pulse_start();
        @(posedge clk);
        #2;
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
    endtask

    task automatic pop_result();
        @(posedge clk);
        #2;
        pop = 1'b1;
        @(posedge clk);
        #2;
        pop = 1'b0;
    endtask

    task automatic load_case(input int c);
        j_row_t row;
        int     v;
        for (int r = 0; r < NUM_SPIN; r++) begin
            for (int k = 0; k < NUM_SPIN; k++) begin
                if (!cases[c].rand_j) begin
                    j_model[r][k] = int'(j_table[r][k]);
                end else if (k == r) begin
                    j_model[r][k] = 0;
                end else if (k > r) begin
                    v = $random(seed) % 8;
                    j_model[r][k] = v;
                    j_model[k][r] = v;
                end
            end
        end
        for (int r = 0; r < NUM_SPIN; r++) begin
            for (int k = 0; k < NUM_SPIN; k++) begin
                row[k] = coup_t'(j_model[r][k]);
            end
            write_host(OP_WRITE_J, ADDR_BIT'(r), row);
            h_model[r] = int'(cases[c].h[r]);
        end
        m_model = cases[c].mask;
        s_model = cases[c].init;
        write_host(OP_WRITE_H, '0, cases[c].h);
        write_host(OP_WRITE_MASK, '0, J_ROW_BIT'(cases[c].mask));
        write_host(OP_LOAD_SPIN, '0, J_ROW_BIT'(cases[c].init));
    endtask

    // Start a sweep and wait for busy_o to drop
    task automatic run_sweep();
        int cycles;
        pulse_start();
        cycles = 0;
        while (busy && cycles < 4 * LATENCY) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (busy) begin
            $display("busy_o still high %0d cycles after a start, at %0t ns", cycles, $time);
            other_errs++;
        end else begin
            check_count("busy_o latency", cycles, LATENCY);
        end
        model_sweep();
    endtask

    task automatic check_head();
        spin_vec_t  spins;
        energy_t    energy;
        check_level("result_valid_o", result_valid, 1'b1);
        if (exp_spins.size() == 0) begin
            $display("No expected result is left for the FIFO head at %0t ns", $time);
            other_errs++;
        end else begin
            spins  = exp_spins.pop_front();
            energy = exp_energy.pop_front();
            check_spins("result_o.spins", result.spins, spins);
            check_energy("result_o.energy", result.energy, energy);
        end
    endtask

    // Fill the FIFO, then a further start must be dropped
    task automatic run_back_pressure(input int c);
        for (int n = 0; n < cases[c].sweeps; n++) begin
            run_sweep();
        end
        pulse_start();
        repeat (2) @(posedge clk);
        #1;
        check_level("busy_o", busy, 1'b0);
        for (int n = 0; n < cases[c].sweeps; n++) begin
            check_head();
            pop_result();
        end
        check_level("result_valid_o", result_valid, 1'b0);
    endtask

    task automatic report_and_finish();
        int assert_errs;
        assert_errs = dut.u_checker.assert_fails;
        $display("Errors: %0d value, %0d other, %0d assertion, timeout %0d",
                 value_errs, other_errs, assert_errs, timed_out);
        if (value_errs + other_errs + assert_errs == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////////////////////////
    initial begin : main
        host_wr = '{op: OP_NOP, addr: '0, data: '0};
        start   = 1'b0;
        pop     = 1'b0;
        rst_n   = 1'b0;
        fill_tables();
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        check_level("busy_o", busy, 1'b0);
        check_level("result_valid_o", result_valid, 1'b0);
        for (int c = 0; c < NUM_CASES; c++) begin
            load_case(c);
            if (cases[c].hold) begin
                run_back_pressure(c);
            end else begin
                for (int n = 0; n < cases[c].sweeps; n++) begin
                    run_sweep();
                    check_head();
                    pop_result();
                    check_level("result_valid_o", result_valid, 1'b0);
                end
            end
        end
        report_and_finish();
    end

    initial begin : watchdog
        int limit;
        @(posedge clk);
        limit = NUM_CASES * MAX_SWEEPS * (NUM_SPIN + 10) + 200;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not end within %0d clock cycles", limit);
        timed_out = 1'b1;
        report_and_finish();
    end

endmodule

//--- ising_core.f
logic/ising_pkg.sv
logic/coupling_mem.sv
logic/field_unit.sv
logic/energy_unit.sv
logic/sweep_ctrl.sv
logic/result_fifo.sv
logic/ising_core.sv
sim/tb_clock_gen.sv
sim/ising_checker.sv
sim/tb_ising_core.sv

//--- Makefile
# Verilator build and run of the Ising core testbench
SIM  := obj_dir/Vtb_ising_core
SRCS := $(shell grep -v '^+' ising_core.f)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) ising_core.f
	verilator --binary --assert --top-module tb_ising_core -f ising_core.f

# The simulation passes only if the pass line shows up in its output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
